// File: Makefile
TOP = lsu_tb

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Regression passed'

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: hw/load_extender.sv
// response stage of the load/store unit, aligns and sign or zero extends returned read data
`default_nettype none
`timescale 1ns/1ps

module load_extender import lsu_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,

	// lane order
	input  logic                 endian_i,

	// read issue from the formatter
	input  logic                 rd_issue_i,
	input  load_tag_t            rd_tag_i,

	// bus read data, valid the cycle after issue
	input  logic [WORD_BITS-1:0] dbus_rdata_i,

	// response port, one cycle per load
	output logic                 rsp_valid_o,
	output logic [WORD_BITS-1:0] rsp_data_o
);

	// read awaiting its data
	logic                 pending;
	load_tag_t            tag_q;

	// lane of the pending read
	logic [LANE_BITS-1:0] byte_lane;
	logic                 half_lane;

	// picked lanes
	logic [7:0]           rdata_b;
	logic [15:0]          rdata_h;
	logic [WORD_BITS-1:0] rdata_ext;

	// --------------------
	// issue tracking
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
		end else begin
			pending <= rd_issue_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_issue_i) begin
			tag_q <= rd_tag_i;
		end
	end

	// --------------------
	// lane pick
	// --------------------

	// same endian rule as the store side
	assign byte_lane = tag_q.lane ^ {LANE_BITS{endian_i}};
	assign half_lane = tag_q.lane[1] ^ endian_i;

	assign rdata_b = dbus_rdata_i[byte_lane * 8 +: 8];
	assign rdata_h = dbus_rdata_i[half_lane * 16 +: 16];

	// --------------------
	// extension
	// --------------------

	always_comb begin
		case (tag_q.size)
			SIZE_BYTE: begin
				// top bit fill unless unsigned
				rdata_ext = {{(WORD_BITS - 8){rdata_b[7] & !tag_q.uns}}, rdata_b};
			end
			SIZE_HALF: begin
				rdata_ext = {{(WORD_BITS - 16){rdata_h[15] & !tag_q.uns}}, rdata_h};
			end
			default: begin
				rdata_ext = dbus_rdata_i;
			end
		endcase
	end

	assign rsp_valid_o = pending;
	assign rsp_data_o  = rdata_ext;

endmodule

`default_nettype wire

// File: hw/lsu_pkg.sv
// size codes and request, bus and tag structs shared by the load/store unit and its testbench
`default_nettype none

package lsu_pkg;

	// --------------------
	// bus geometry
	// --------------------

	// byte lanes on the data bus
	localparam int WORD_BYTES = 4;

	// derived widths
	localparam int WORD_BITS  = 8 * WORD_BYTES;
	localparam int LANE_BITS  = $clog2(WORD_BYTES);

	// --------------------
	// access size
	// --------------------

	// 2'b11 is not issued, treated as a word
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} mem_size_t;

	// --------------------
	// structs
	// --------------------

	// request as it arrives from the memory stage
	typedef struct packed {
		logic                 we;
		mem_size_t            size;
		// zero fill on load
		logic                 uns;
		logic [31:0]          addr;
		logic [WORD_BITS-1:0] wdata;
	} mem_req_t;

	// word addressed data bus request
	typedef struct packed {
		logic [31-LANE_BITS:0] addr;
		logic                  we;
		logic [WORD_BYTES-1:0] sel;
		logic [WORD_BITS-1:0]  wdata;
	} dbus_req_t;

	// what a read needs once its data comes back
	typedef struct packed {
		logic [LANE_BITS-1:0] lane;
		mem_size_t            size;
		logic                 uns;
	} load_tag_t;

endpackage

`default_nettype wire

// File: hw/lsu_top.sv
// top level of the load/store unit, connects the request formatter to the load extender
`default_nettype none
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,

	// lane order
	input  logic                 endian_i,

	// request port
	input  logic                 req_valid_i,
	input  mem_req_t             req_i,
	output logic                 req_ready_o,

	// data bus
	output logic                 dbus_valid_o,
	output dbus_req_t            dbus_req_o,
	input  logic                 dbus_ready_i,
	input  logic [WORD_BITS-1:0] dbus_rdata_i,

	// load response
	output logic                 rsp_valid_o,
	output logic [WORD_BITS-1:0] rsp_data_o
);

	// read accepted on the bus and its tag
	logic      rd_issue;
	load_tag_t rd_tag;

	// --------------------
	// request side
	// --------------------

	store_formatter u_store_formatter (
		.clk          (clk),
		.reset        (reset),
		.endian_i     (endian_i),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.req_ready_o  (req_ready_o),
		.dbus_valid_o (dbus_valid_o),
		.dbus_req_o   (dbus_req_o),
		.dbus_ready_i (dbus_ready_i),
		.rd_issue_o   (rd_issue),
		.rd_tag_o     (rd_tag)
	);

	// --------------------
	// response side
	// --------------------

	load_extender u_load_extender (
		.clk          (clk),
		.reset        (reset),
		.endian_i     (endian_i),
		.rd_issue_i   (rd_issue),
		.rd_tag_i     (rd_tag),
		.dbus_rdata_i (dbus_rdata_i),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_data_o   (rsp_data_o)
	);

endmodule

`default_nettype wire

// File: hw/store_formatter.sv
// request stage of the load/store unit, forms lane selects and write data and holds the bus request
`default_nettype none
`timescale 1ns/1ps

module store_formatter import lsu_pkg::*; (
	input  logic      clk,
	input  logic      reset,

	// lane order
	input  logic      endian_i,

	// request port
	input  logic      req_valid_i,
	input  mem_req_t  req_i,
	output logic      req_ready_o,

	// data bus request
	output logic      dbus_valid_o,
	output dbus_req_t dbus_req_o,
	input  logic      dbus_ready_i,

	// read issue toward the load extender
	output logic      rd_issue_o,
	output load_tag_t rd_tag_o
);

	// lane of the incoming request
	logic [LANE_BITS-1:0]  byte_lane;
	logic                  half_lane;

	// formatted request before the register
	logic [WORD_BYTES-1:0] lane_sel;
	logic [WORD_BITS-1:0]  lane_wdata;
	dbus_req_t             next_req;
	load_tag_t             next_tag;

	// one entry output stage
	logic                  held_valid;
	dbus_req_t             held_req;
	load_tag_t             held_tag;

	// handshakes
	logic                  bus_accept;
	logic                  req_take;

	// --------------------
	// lane selection
	// --------------------

	// big endian flips the lane numbering
	assign byte_lane = req_i.addr[LANE_BITS-1:0] ^ {LANE_BITS{endian_i}};
	assign half_lane = req_i.addr[1] ^ endian_i;

	always_comb begin
		lane_sel   = '1;
		lane_wdata = req_i.wdata;
		case (req_i.size)
			SIZE_BYTE: begin
				for (int i = 0; i < WORD_BYTES; i++) begin
					lane_sel[i] = (byte_lane == LANE_BITS'(i));
				end
				lane_wdata = {WORD_BYTES{req_i.wdata[7:0]}};
			end
			SIZE_HALF: begin
				for (int i = 0; i < WORD_BYTES; i++) begin
					lane_sel[i] = (half_lane == 1'(i >> 1));
				end
				lane_wdata = {(WORD_BYTES / 2){req_i.wdata[15:0]}};
			end
			default: begin
				// whole word on all lanes
				lane_sel   = '1;
				lane_wdata = req_i.wdata;
			end
		endcase
	end

	// reads always fetch the full word
	assign next_req.addr  = req_i.addr[31:LANE_BITS];
	assign next_req.we    = req_i.we;
	assign next_req.sel   = req_i.we ? lane_sel : '1;
	assign next_req.wdata = lane_wdata;

	// raw low address bits, the extender applies the endian rule itself
	assign next_tag.lane  = req_i.addr[LANE_BITS-1:0];
	assign next_tag.size  = req_i.size;
	assign next_tag.uns   = req_i.uns;

	// --------------------
	// output stage
	// --------------------

	assign bus_accept  = held_valid & dbus_ready_i;

	// room when empty or draining this cycle
	assign req_ready_o = !held_valid | dbus_ready_i;
	assign req_take    = req_valid_i & req_ready_o;

	always_ff @(posedge clk) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (req_ready_o) begin
			held_valid <= req_valid_i;
		end
	end

	// payload only moves on a taken request, so a stall keeps it stable
	always_ff @(posedge clk) begin
		if (req_take) begin
			held_req <= next_req;
			held_tag <= next_tag;
		end
	end

	assign dbus_valid_o = held_valid;
	assign dbus_req_o   = held_req;

	// read data follows one cycle after this
	assign rd_issue_o   = bus_accept & !held_req.we;
	assign rd_tag_o     = held_tag;

endmodule

`default_nettype wire

// File: list.f
hw/lsu_pkg.sv
hw/store_formatter.sv
hw/load_extender.sv
hw/lsu_top.sv
sim/dbus_memory.sv
sim/lsu_checker.sv
sim/lsu_properties.sv
sim/lsu_tb.sv

// File: sim/dbus_memory.sv
// testbench data bus memory, writes bytes by lane select and stalls ready at random
`default_nettype none
`timescale 1ns/1ps

module dbus_memory import lsu_pkg::*; #(
	parameter int SEED = 1
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 dbus_valid_i,
	input  dbus_req_t            dbus_req_i,
	output logic                 dbus_ready_o,
	output logic [WORD_BITS-1:0] dbus_rdata_o
);

	logic [WORD_BITS-1:0] mem [256];
	logic [WORD_BITS-1:0] rdata_q = '0;
	logic [31:0]          lcg_state = 32'(SEED);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		dbus_ready_o = 1'b1;
		// fill depends on the whole word address
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'(i) * 32'h9E37_79B1;
		end
	end

	// about one stall cycle in four
	always @(negedge clk) begin
		lcg_state = lcg_next(lcg_state);
		dbus_ready_o = (lcg_state[31:30] != 2'b00);
	end

	always @(posedge clk) begin
		if (!reset && dbus_valid_i && dbus_ready_o) begin
			if (dbus_req_i.we) begin
				for (int b = 0; b < WORD_BYTES; b++) begin
					if (dbus_req_i.sel[b]) begin
						mem[dbus_req_i.addr[7:0]][b*8 +: 8] = dbus_req_i.wdata[b*8 +: 8];
					end
				end
			end else begin
				rdata_q <= mem[dbus_req_i.addr[7:0]];
			end
		end
	end

	assign dbus_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: sim/lsu_checker.sv
// testbench checker, queues expected load values at request time and compares each response
`default_nettype none
`timescale 1ns/1ps

module lsu_checker (
	input  logic        clk,
	input  logic        reset,
	input  logic        req_valid_i,
	input  logic        req_ready_i,
	input  logic        req_we_i,
	input  logic [31:0] exp_data_i,
	input  logic        dbus_valid_i,
	input  logic        rsp_valid_i,
	input  logic [31:0] rsp_data_i,
	output int          loads_done_o,
	output int          errors_o
);

	logic [31:0] expected_q [$];
	logic [31:0] expected;
	int          stores = 0;

	initial begin
		loads_done_o = 0;
		errors_o = 0;
	end

	always @(posedge clk) begin
		if (reset) begin
			if (dbus_valid_i === 1'b1 || rsp_valid_i === 1'b1) begin
				$display("bus request or load response raised during reset");
				errors_o++;
			end
		end else begin
			if (req_valid_i && req_ready_i) begin
				if (req_we_i) begin
					stores++;
					$display("store %0d accepted", stores);
				end else begin
					expected_q.push_back(exp_data_i);
				end
			end
			// --------------------
			// responses
			// --------------------
			if (rsp_valid_i) begin
				loads_done_o++;
				if (expected_q.size() == 0) begin
					$display("load response arrived with no load outstanding");
					errors_o++;
				end else begin
					expected = expected_q.pop_front();
					if (rsp_data_i !== expected) begin
						$display("Error: rsp_data_o = 0x%08h, expected 0x%08h", rsp_data_i,
							expected);
						errors_o++;
					end else begin
						$display("load %0d: rsp_data_o = 0x%08h ok", loads_done_o, rsp_data_i);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/lsu_properties.sv
// concurrent checks on the data bus handshake and load response timing, bound into the top level
`default_nettype none
`timescale 1ns/1ps

module lsu_properties import lsu_pkg::*; (
	input logic      clk,
	input logic      reset,
	input logic      dbus_valid_i,
	input dbus_req_t dbus_req_i,
	input logic      dbus_ready_i,
	input logic      rsp_valid_i
);

	logic read_accept;
	int   stall_fails = 0;
	int   rsp_fails = 0;

	assign read_accept = dbus_valid_i && dbus_ready_i && !dbus_req_i.we;

	// stalled request holds until taken
	a_stall_stable: assert property (@(posedge clk) disable iff (reset)
		dbus_valid_i && !dbus_ready_i |=> dbus_valid_i && $stable(dbus_req_i))
	else begin
		$error("dbus request changed while stalled");
		stall_fails++;
	end

	// response exactly one cycle after a read is taken
	a_rsp_timing: assert property (@(posedge clk) disable iff (reset)
		rsp_valid_i == $past(read_accept))
	else begin
		$error("load response not one cycle after read acceptance");
		rsp_fails++;
	end

endmodule

bind lsu_top lsu_properties u_lsu_properties (
	.clk          (clk),
	.reset        (reset),
	.dbus_valid_i (dbus_valid_o),
	.dbus_req_i   (dbus_req_o),
	.dbus_ready_i (dbus_ready_i),
	.rsp_valid_i  (rsp_valid_o)
);

`default_nettype wire

// File: sim/lsu_tb.sv
// testbench top for the load/store unit, runs the stimulus table and reports the result
`default_nettype none
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS    = 26;
	localparam int MAX_CYCLES   = RESET_CYCLES + NUM_TESTS * 16;

	typedef struct packed {
		logic        endian;
		logic        we;
		mem_size_t   size;
		logic        uns;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] expected;
	} test_entry_t;

	// endian, write, size, unsigned, address, write data, expected load
	localparam test_entry_t TESTS [NUM_TESTS] = '{
		'{1'b0, 1'b1, SIZE_WORD, 1'b0, 32'h0000_0000, 32'h1122_3344, 32'h0000_0000},
		'{1'b0, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 32'h0000_0000, 32'h1122_3344},
		'{1'b0, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0010, 32'h5A5A_5A81, 32'h0000_0000},
		'{1'b0, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0011, 32'h5A5A_5A02, 32'h0000_0000},
		'{1'b0, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0012, 32'h5A5A_5A83, 32'h0000_0000},
		'{1'b0, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0013, 32'h5A5A_5A04, 32'h0000_0000},
		'{1'b0, 1'b0, SIZE_BYTE, 1'b0, 32'h0000_0010, 32'h0000_0000, 32'hFFFF_FF81},
		'{1'b0, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0010, 32'h0000_0000, 32'h0483_0281},
		'{1'b0, 1'b1, SIZE_HALF, 1'b0, 32'h0000_0030, 32'hA5A5_8765, 32'h0000_0000},
		'{1'b0, 1'b1, SIZE_HALF, 1'b0, 32'h0000_0032, 32'hA5A5_1234, 32'h0000_0000},
		'{1'b0, 1'b0, SIZE_HALF, 1'b0, 32'h0000_0030, 32'h0000_0000, 32'hFFFF_8765},
		'{1'b0, 1'b0, SIZE_HALF, 1'b1, 32'h0000_0030, 32'h0000_0000, 32'h0000_8765},
		'{1'b0, 1'b0, SIZE_HALF, 1'b0, 32'h0000_0032, 32'h0000_0000, 32'h0000_1234},
		// big endian from here
		'{1'b1, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 32'h0000_0000, 32'h1122_3344},
		'{1'b1, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0020, 32'h5A5A_5AA1, 32'h0000_0000},
		'{1'b1, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0021, 32'h5A5A_5A22, 32'h0000_0000},
		'{1'b1, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0022, 32'h5A5A_5AB3, 32'h0000_0000},
		'{1'b1, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0023, 32'h5A5A_5A44, 32'h0000_0000},
		'{1'b1, 1'b0, SIZE_WORD, 1'b0, 32'h0000_0020, 32'h0000_0000, 32'hA122_B344},
		'{1'b1, 1'b0, SIZE_BYTE, 1'b1, 32'h0000_0020, 32'h0000_0000, 32'h0000_00A1},
		'{1'b1, 1'b0, SIZE_BYTE, 1'b0, 32'h0000_0022, 32'h0000_0000, 32'hFFFF_FFB3},
		'{1'b1, 1'b1, SIZE_HALF, 1'b0, 32'h0000_0040, 32'hA5A5_C0DE, 32'h0000_0000},
		'{1'b1, 1'b1, SIZE_HALF, 1'b0, 32'h0000_0042, 32'hA5A5_F001, 32'h0000_0000},
		'{1'b1, 1'b0, SIZE_HALF, 1'b0, 32'h0000_0040, 32'h0000_0000, 32'hFFFF_C0DE},
		'{1'b1, 1'b0, SIZE_HALF, 1'b1, 32'h0000_0042, 32'h0000_0000, 32'h0000_F001},
		'{1'b0, 1'b0, SIZE_BYTE, 1'b1, 32'h0000_0040, 32'h0000_0000, 32'h0000_0001}
	};

	logic        clk;
	logic        reset;
	logic        endian_i;
	logic        req_valid_i;
	mem_req_t    req_i;
	logic        req_ready_o;
	logic        dbus_valid_o;
	dbus_req_t   dbus_req_o;
	logic        dbus_ready_i;
	logic [31:0] dbus_rdata_i;
	logic        rsp_valid_o;
	logic [31:0] rsp_data_o;
	logic [31:0] exp_data;
	logic        req_taken = 1'b0;
	int          loads_sent = 0;
	int          loads_done;
	int          load_errors;
	int          errors;
	int          cycles = 0;

	lsu_top uut (.*);

	dbus_memory #(
		.SEED (30279)
	) u_dbus_memory (
		.clk          (clk),
		.reset        (reset),
		.dbus_valid_i (dbus_valid_o),
		.dbus_req_i   (dbus_req_o),
		.dbus_ready_o (dbus_ready_i),
		.dbus_rdata_o (dbus_rdata_i)
	);

	lsu_checker u_lsu_checker (
		.clk          (clk),
		.reset        (reset),
		.req_valid_i  (req_valid_i),
		.req_ready_i  (req_ready_o),
		.req_we_i     (req_i.we),
		.exp_data_i   (exp_data),
		.dbus_valid_i (dbus_valid_o),
		.rsp_valid_i  (rsp_valid_o),
		.rsp_data_i   (rsp_data_o),
		.loads_done_o (loads_done),
		.errors_o     (load_errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		req_taken <= !reset && req_valid_i && req_ready_o;
		if (!reset && req_valid_i && req_ready_o && !req_i.we) begin
			loads_sent <= loads_sent + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout after %0d cycles, load responses are missing", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// called on a falling edge, returns on the falling edge after the request is taken
	task automatic apply_entry(input test_entry_t e);
		// in-flight loads pick their lane under the old endian
		if (e.endian != endian_i) begin
			req_valid_i = 1'b0;
			while (dbus_valid_o || loads_done != loads_sent) begin
				@(negedge clk);
			end
			endian_i = e.endian;
		end
		req_valid_i = 1'b1;
		req_i = '{e.we, e.size, e.uns, e.addr, e.wdata};
		exp_data = e.expected;
		do begin
			@(negedge clk);
		end while (!req_taken);
	endtask

	initial begin
		reset = 1'b1;
		endian_i = 1'b0;
		// a load offered during reset must never reach the bus
		req_valid_i = 1'b1;
		req_i = '0;
		exp_data = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		req_valid_i = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			apply_entry(TESTS[t]);
		end
		req_valid_i = 1'b0;
		while (loads_done != loads_sent) begin
			@(negedge clk);
		end
		errors = load_errors + uut.u_lsu_properties.stall_fails
			+ uut.u_lsu_properties.rsp_fails;
		$display("%0d tests, %0d loads checked, %0d errors", NUM_TESTS, loads_done, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
